// ==== src/raster_cfg.svh ====
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// line pitch in pixels after reset
// a 640 wide frame
`define RASTER_PITCH_RESET 16'd640

// log2 of bytes per pixel in the frame buffer
// 8 byte pixels: color plus depth
`define RASTER_PIXEL_SHIFT 3

// frame buffer byte address width
`define RASTER_ADDR_W 26

`endif

// ==== src/raster_pkg.sv ====
package raster_pkg;

    // integer and fraction halves of a 16.16 word
    typedef struct packed {
        logic signed [15:0] int_part;
        logic [15:0]        frac_part;
    } fix16_parts_t;

    // 16.16 coordinate, whole number or split view
    typedef union packed {
        logic signed [31:0] raw;
        fix16_parts_t       parts;
    } fix16_u;

    // screen x, y plus depth, x in the top bits
    typedef struct packed {
        fix16_u x;
        fix16_u y;
        fix16_u z;
    } vertex_t;

    // ccw only drops back-facing triangles
    typedef enum logic {
        wind_ccw_only = 1'b0,
        wind_both     = 1'b1
    } winding_e;

    // 16.16 product, keeps the middle 32 bits
    function automatic logic signed [31:0] fp_mul(
        input logic signed [31:0] a,
        input logic signed [31:0] b
    );
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(b);
        return prod[47:16];
    endfunction

    // 16.16 quotient, zero for a degenerate divisor
    function automatic logic signed [31:0] fp_div(
        input logic signed [31:0] num,
        input logic signed [31:0] den
    );
        logic signed [63:0] wide_num;
        logic signed [63:0] quot;
        wide_num = 64'(num) <<< 16;
        if (den == 0) begin
            quot = '0;
        end else begin
            quot = wide_num / 64'(den);
        end
        return quot[31:0];
    endfunction

endpackage

// ==== src/tri_if.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

interface tri_if;
    import raster_pkg::*;

    // latched vertices
    vertex_t v1;
    vertex_t v2;
    vertex_t v3;
    // flat color of vertex 1
    logic [23:0] color;
    logic [`RASTER_ADDR_W-1:0] base_addr;
    // integer bounding box
    logic signed [15:0] min_x;
    logic signed [15:0] max_x;
    logic signed [15:0] min_y;
    logic signed [15:0] max_y;
    // barycentric denominator, 16.16
    logic signed [31:0] denom;
    logic done_flag;
    // walk request and completion, single cycle each
    logic start;
    logic finished;

    modport setup (
        output v1, v2, v3, color, base_addr,
        output min_x, max_x, min_y, max_y, denom,
        output done_flag, start,
        input  finished
    );

    modport walk (
        input  v1, v2, v3, color, base_addr,
        input  min_x, max_x, min_y, max_y, denom,
        input  done_flag, start,
        output finished
    );

endinterface

// ==== src/raster_regs.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module raster_regs (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 reg_write,
    input  logic                 reg_addr,
    input  logic [15:0]          reg_wdata,
    output logic [15:0]          reg_rdata,
    output logic [15:0]          pitch,
    output raster_pkg::winding_e winding
);
    import raster_pkg::*;

    // address 0 is pitch, address 1 is winding
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pitch   <= `RASTER_PITCH_RESET;
            winding <= wind_both;
        end else if (reg_write) begin
            if (reg_addr == 1'b0) begin
                pitch <= reg_wdata;
            end else begin
                // only bit 0 is stored
                winding <= winding_e'(reg_wdata[0]);
            end
        end
    end

    // read-back mux, no register stage
    always_comb begin
        if (reg_addr == 1'b0) begin
            reg_rdata = pitch;
        end else begin
            reg_rdata = {15'd0, winding};
        end
    end

endmodule

// ==== src/tri_setup.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module tri_setup (
    input  logic [31:0]               x1,
    input  logic                      clock,
    input  logic                      reset,
    input  logic [31:0]               y1,
    input  logic [31:0]               z1,
    input  logic [31:0]               x2,
    input  logic [31:0]               y2,
    input  logic [31:0]               z2,
    input  logic [31:0]               x3,
    input  logic [31:0]               y3,
    input  logic [31:0]               z3,
    input  logic [23:0]               color1,
    input  logic [`RASTER_ADDR_W-1:0] addr_in,
    input  logic                      in_data_valid,
    input  logic                      done_in,
    output logic                      stall_out,
    tri_if.setup                      tri_bus
);
    import raster_pkg::*;

    logic busy;
    logic accept;
    // latched vertices waiting for box and denominator
    logic setup_pend;

    function automatic logic signed [15:0] min3(
        input logic signed [15:0] a,
        input logic signed [15:0] b,
        input logic signed [15:0] c
    );
        logic signed [15:0] m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic logic signed [15:0] max3(
        input logic signed [15:0] a,
        input logic signed [15:0] b,
        input logic signed [15:0] c
    );
        logic signed [15:0] m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // one triangle in flight at a time
    assign accept    = in_data_valid && !busy;
    assign stall_out = busy;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            busy          <= 1'b0;
            setup_pend    <= 1'b0;
            tri_bus.start <= 1'b0;
        end else begin
            setup_pend    <= accept;
            // walker kicks off once box and denom are settled
            tri_bus.start <= setup_pend;
            if (accept) begin
                busy <= 1'b1;
            end else if (tri_bus.finished) begin
                busy <= 1'b0;
            end
        end
    end

    // stage 1 captures the raw triangle
    always_ff @(posedge clock) begin
        if (accept) begin
            tri_bus.v1        <= {x1, y1, z1};
            tri_bus.v2        <= {x2, y2, z2};
            tri_bus.v3        <= {x3, y3, z3};
            tri_bus.color     <= color1;
            tri_bus.base_addr <= addr_in;
            tri_bus.done_flag <= done_in;
        end
    end

    // stage 2, whole-pixel box plus shared denominator
    always_ff @(posedge clock) begin
        if (setup_pend) begin
            tri_bus.min_x <= min3(tri_bus.v1.x.parts.int_part, tri_bus.v2.x.parts.int_part,
                                  tri_bus.v3.x.parts.int_part);
            tri_bus.max_x <= max3(tri_bus.v1.x.parts.int_part, tri_bus.v2.x.parts.int_part,
                                  tri_bus.v3.x.parts.int_part);
            tri_bus.min_y <= min3(tri_bus.v1.y.parts.int_part, tri_bus.v2.y.parts.int_part,
                                  tri_bus.v3.y.parts.int_part);
            tri_bus.max_y <= max3(tri_bus.v1.y.parts.int_part, tri_bus.v2.y.parts.int_part,
                                  tri_bus.v3.y.parts.int_part);
            // (y2 - y3)(x1 - x3) + (x3 - x2)(y1 - y3)
            tri_bus.denom <= fp_mul(tri_bus.v2.y.raw - tri_bus.v3.y.raw,
                                    tri_bus.v1.x.raw - tri_bus.v3.x.raw)
                           + fp_mul(tri_bus.v3.x.raw - tri_bus.v2.x.raw,
                                    tri_bus.v1.y.raw - tri_bus.v3.y.raw);
        end
    end

endmodule

// ==== src/pixel_walker.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module pixel_walker (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      stall_in,
    input  logic [15:0]               pitch,
    input  raster_pkg::winding_e      winding,
    tri_if.walk                       tri_bus,
    output logic [`RASTER_ADDR_W-1:0] addr_out,
    output logic [23:0]               color_out,
    output logic [31:0]               depth_out,
    output logic                      output_valid,
    output logic                      done_out
);
    import raster_pkg::*;

    // 1.0 in 16.16
    localparam logic signed [31:0] fix_one = 32'sh0001_0000;

    typedef enum logic [1:0] {
        st_idle,
        st_walk,
        st_drain
    } walk_state_e;

    walk_state_e state;
    logic signed [15:0] cur_x;
    logic signed [15:0] cur_y;
    fix16_u pos_x;
    fix16_u pos_y;
    logic signed [39:0] e12;
    logic signed [39:0] e23;
    logic signed [39:0] e31;
    logic covered;
    logic last_pixel;
    logic hold;
    logic signed [31:0] w1_num;
    logic signed [31:0] w2_num;
    logic signed [31:0] w1;
    logic signed [31:0] w2;
    logic signed [31:0] w3;
    logic signed [31:0] depth;
    logic signed [31:0] pix_idx;
    logic [`RASTER_ADDR_W-1:0] pix_off;
    logic [`RASTER_ADDR_W-1:0] pix_addr;

    // (p - a) x (b - a) on whole pixels
    function automatic logic signed [39:0] edge_fn(
        input logic signed [15:0] ax,
        input logic signed [15:0] ay,
        input logic signed [15:0] bx,
        input logic signed [15:0] by,
        input logic signed [15:0] px,
        input logic signed [15:0] py
    );
        logic signed [19:0] dpx;
        logic signed [19:0] dpy;
        logic signed [19:0] dex;
        logic signed [19:0] dey;
        dpx = 20'(px) - 20'(ax);
        dpy = 20'(py) - 20'(ay);
        dex = 20'(bx) - 20'(ax);
        dey = 20'(by) - 20'(ay);
        return 40'(dpx) * 40'(dey) - 40'(dpy) * 40'(dex);
    endfunction

    // a pending pixel that downstream refuses freezes everything
    assign hold       = output_valid && stall_in;
    assign last_pixel = (cur_x >= tri_bus.max_x) && (cur_y >= tri_bus.max_y);

    always_comb begin
        e12 = edge_fn(tri_bus.v1.x.parts.int_part, tri_bus.v1.y.parts.int_part,
                      tri_bus.v2.x.parts.int_part, tri_bus.v2.y.parts.int_part, cur_x, cur_y);
        e23 = edge_fn(tri_bus.v2.x.parts.int_part, tri_bus.v2.y.parts.int_part,
                      tri_bus.v3.x.parts.int_part, tri_bus.v3.y.parts.int_part, cur_x, cur_y);
        e31 = edge_fn(tri_bus.v3.x.parts.int_part, tri_bus.v3.y.parts.int_part,
                      tri_bus.v1.x.parts.int_part, tri_bus.v1.y.parts.int_part, cur_x, cur_y);
        // all non-negative, or all non-positive for cw when allowed
        covered = (e12 >= 0 && e23 >= 0 && e31 >= 0)
               || (winding == wind_both && e12 <= 0 && e23 <= 0 && e31 <= 0);
    end

    // barycentric depth at the pixel corner
    always_comb begin
        pos_x.parts.int_part  = cur_x;
        pos_x.parts.frac_part = 16'h0000;
        pos_y.parts.int_part  = cur_y;
        pos_y.parts.frac_part = 16'h0000;
        w1_num = fp_mul(tri_bus.v2.y.raw - tri_bus.v3.y.raw, pos_x.raw - tri_bus.v3.x.raw)
               + fp_mul(tri_bus.v3.x.raw - tri_bus.v2.x.raw, pos_y.raw - tri_bus.v3.y.raw);
        w2_num = fp_mul(tri_bus.v3.y.raw - tri_bus.v1.y.raw, pos_x.raw - tri_bus.v3.x.raw)
               + fp_mul(tri_bus.v1.x.raw - tri_bus.v3.x.raw, pos_y.raw - tri_bus.v3.y.raw);
        w1 = fp_div(w1_num, tri_bus.denom);
        w2 = fp_div(w2_num, tri_bus.denom);
        // weights sum to exactly one
        w3 = fix_one - w1 - w2;
        depth = fp_mul(w1, tri_bus.v1.z.raw) + fp_mul(w2, tri_bus.v2.z.raw)
              + fp_mul(w3, tri_bus.v3.z.raw);
    end

    // linear pixel index scaled to bytes
    always_comb begin
        pix_idx  = 32'(cur_y) * 32'($signed({1'b0, pitch})) + 32'(cur_x);
        pix_off  = pix_idx[`RASTER_ADDR_W-1:0] << `RASTER_PIXEL_SHIFT;
        pix_addr = tri_bus.base_addr + pix_off;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state            <= st_idle;
            cur_x            <= '0;
            cur_y            <= '0;
            output_valid     <= 1'b0;
            done_out         <= 1'b0;
            tri_bus.finished <= 1'b0;
        end else begin
            // pulses by default
            tri_bus.finished <= 1'b0;
            done_out         <= 1'b0;
            if (!hold) begin
                case (state)
                    st_idle: begin
                        output_valid <= 1'b0;
                        if (tri_bus.start) begin
                            cur_x <= tri_bus.min_x;
                            cur_y <= tri_bus.min_y;
                            state <= st_walk;
                        end
                    end
                    st_walk: begin
                        output_valid <= covered;
                        if (last_pixel) begin
                            state <= st_drain;
                        end else if (cur_x >= tri_bus.max_x) begin
                            // row done, back to left edge
                            cur_x <= tri_bus.min_x;
                            cur_y <= cur_y + 16'sd1;
                        end else begin
                            cur_x <= cur_x + 16'sd1;
                        end
                    end
                    st_drain: begin
                        // last pixel consumed on this edge
                        output_valid     <= 1'b0;
                        tri_bus.finished <= 1'b1;
                        done_out         <= tri_bus.done_flag;
                        state            <= st_idle;
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // pixel payload, loaded only for covered pixels
    always_ff @(posedge clock) begin
        if (state == st_walk && !hold && covered) begin
            addr_out  <= pix_addr;
            color_out <= tri_bus.color;
            depth_out <= depth;
        end
    end

endmodule

// ==== src/raster_top.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module raster_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [31:0]               x1,
    input  logic [31:0]               y1,
    input  logic [31:0]               z1,
    input  logic [31:0]               x2,
    input  logic [31:0]               y2,
    input  logic [31:0]               z2,
    input  logic [31:0]               x3,
    input  logic [31:0]               y3,
    input  logic [31:0]               z3,
    input  logic [23:0]               color1,
    input  logic [`RASTER_ADDR_W-1:0] addr_in,
    input  logic                      in_data_valid,
    input  logic                      done_in,
    input  logic                      stall_in,
    input  logic                      reg_write,
    input  logic                      reg_addr,
    input  logic [15:0]               reg_wdata,
    output logic [15:0]               reg_rdata,
    output logic [`RASTER_ADDR_W-1:0] addr_out,
    output logic [23:0]               color_out,
    output logic [31:0]               depth_out,
    output logic                      output_valid,
    output logic                      stall_out,
    output logic                      done_out
);
    import raster_pkg::*;

    logic [15:0] pitch;
    winding_e    winding;

    // setup to walker triangle handoff
    tri_if u_tri_if ();

    raster_regs u_regs (
        .clock     (clock),
        .reset     (reset),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .pitch     (pitch),
        .winding   (winding)
    );

    tri_setup u_setup (
        .clock         (clock),
        .reset         (reset),
        .x1            (x1),
        .y1            (y1),
        .z1            (z1),
        .x2            (x2),
        .y2            (y2),
        .z2            (z2),
        .x3            (x3),
        .y3            (y3),
        .z3            (z3),
        .color1        (color1),
        .addr_in       (addr_in),
        .in_data_valid (in_data_valid),
        .done_in       (done_in),
        .stall_out     (stall_out),
        .tri_bus       (u_tri_if.setup)
    );

    pixel_walker u_walker (
        .clock        (clock),
        .reset        (reset),
        .stall_in     (stall_in),
        .pitch        (pitch),
        .winding      (winding),
        .tri_bus      (u_tri_if.walk),
        .addr_out     (addr_out),
        .color_out    (color_out),
        .depth_out    (depth_out),
        .output_valid (output_valid),
        .done_out     (done_out)
    );

endmodule

// ==== verif/raster_props.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module raster_props (
    input logic                      clock,
    input logic                      reset,
    input logic                      stall_in,
    input logic                      output_valid,
    input logic                      stall_out,
    input logic                      done_out,
    input logic [`RASTER_ADDR_W-1:0] addr_out,
    input logic [23:0]               color_out,
    input logic [31:0]               depth_out
);

    // end of frame marker lasts one cycle
    done_pulse: assert property (@(posedge clock) disable iff (!reset)
        done_out |=> !done_out)
        else $error("done_out stayed high for more than one cycle");

    // refused pixel stays put until taken
    hold_stable: assert property (@(posedge clock) disable iff (!reset)
        output_valid && stall_in |=> output_valid && $stable(addr_out)
            && $stable(color_out) && $stable(depth_out))
        else $error("pixel outputs changed while stall_in held them");

    // pixels only come out of a busy block
    busy_valid: assert property (@(posedge clock) disable iff (!reset)
        output_valid |-> stall_out)
        else $error("output_valid high while stall_out low");

endmodule

bind raster_top raster_props u_props (
    .clock        (clock),
    .reset        (reset),
    .stall_in     (stall_in),
    .output_valid (output_valid),
    .stall_out    (stall_out),
    .done_out     (done_out),
    .addr_out     (addr_out),
    .color_out    (color_out),
    .depth_out    (depth_out)
);

// ==== verif/raster_tests.svh ====
`ifndef RASTER_TESTS_SVH
`define RASTER_TESTS_SVH

// ccw right triangle at reset pitch, no stalls
task automatic test_coverage();
    int err0;
    int first;
    int d0;
    err0 = errors;
    check(reg_rdata == `RASTER_PITCH_RESET, "pitch register not at its reset value");
    tv = '{4, 4, 4, 14, 14, 4};
    first = got_addr.size();
    d0 = done_count;
    offer_tri(26'h010000, 1'b1);
    wait_idle();
    build_expected(1'b1, 640, 26'h010000);
    compare_pixels(first);
    check(done_count == d0 + 1, "done_out did not pulse once for a done triangle");
    end_test("coverage", err0);
endtask

// narrower pitch, read back, then address per pixel
task automatic test_addressing();
    int err0;
    int first;
    err0 = errors;
    write_reg(1'b0, 16'd320);
    check(reg_rdata == 16'd320, "pitch read back differs from the written 320");
    tv = '{20, 5, 25, 15, 30, 5};
    first = got_addr.size();
    offer_tri(26'h020000, 1'b0);
    wait_idle();
    build_expected(1'b1, 320, 26'h020000);
    compare_pixels(first);
    end_test("addressing", err0);
endtask

// random stall_in, second triangle offered during the first walk
task automatic test_backpressure();
    int err0;
    int first;
    err0 = errors;
    tv = '{4, 4, 4, 14, 14, 4};
    first = got_addr.size();
    stall_random = 1'b1;
    @(posedge clock);
    #1;
    load_tri(26'h030000, 1'b0);
    @(posedge clock);
    #1;
    // valid stays high, only the base changes
    addr_in = 26'h040000;
    while (stall_out) begin
        @(posedge clock);
        #1;
    end
    // all of the first triangle must be out by now
    build_expected(1'b1, 320, 26'h030000);
    compare_pixels(first);
    @(posedge clock);
    #1;
    check(stall_out, "offered triangle not taken once stall_out fell");
    in_data_valid = 1'b0;
    first = first + exp_addr.size();
    wait_idle();
    stall_random = 1'b0;
    build_expected(1'b1, 320, 26'h040000);
    compare_pixels(first);
    end_test("backpressure", err0);
endtask

// cw triangle culled, then accepted with mirrored coverage
task automatic test_winding();
    int err0;
    int first;
    int d0;
    err0 = errors;
    write_reg(1'b1, 16'd0);
    check(reg_rdata == 16'd0, "winding read back is not ccw only");
    tv = '{4, 4, 14, 4, 4, 14};
    first = got_addr.size();
    d0 = done_count;
    offer_tri(26'h050000, 1'b1);
    wait_idle();
    build_expected(1'b0, 320, 26'h050000);
    compare_pixels(first);
    check(done_count == d0 + 1, "done_out did not pulse for a culled done triangle");
    write_reg(1'b1, 16'd1);
    first = got_addr.size();
    d0 = done_count;
    offer_tri(26'h050000, 1'b0);
    wait_idle();
    build_expected(1'b1, 320, 26'h050000);
    compare_pixels(first);
    check(done_count == d0, "done_out pulsed although done_in was clear");
    end_test("winding", err0);
endtask

// quarter-pixel vertices so the weights are uneven, z flat
task automatic test_depth();
    int err0;
    int first;
    err0 = errors;
    frac = 16'h4000;
    zv = 32'h0012_3456;
    col_v = 24'h81c0de;
    tv = '{6, 3, 2, 17, 19, 9};
    first = got_addr.size();
    offer_tri(26'h060000, 1'b0);
    wait_idle();
    build_expected(1'b1, 320, 26'h060000);
    compare_pixels(first);
    end_test("depth", err0);
endtask

`endif

// ==== verif/raster_tb.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module raster_tb;

    // seven triangles with boxes up to 20x20 and about half the cycles stalled in one test
    localparam int cycle_limit = 4000;

    logic clock;
    logic reset;
    logic [31:0] x1;
    logic [31:0] y1;
    logic [31:0] z1;
    logic [31:0] x2;
    logic [31:0] y2;
    logic [31:0] z2;
    logic [31:0] x3;
    logic [31:0] y3;
    logic [31:0] z3;
    logic [23:0] color1;
    logic [`RASTER_ADDR_W-1:0] addr_in;
    logic in_data_valid;
    logic done_in;
    logic stall_in;
    logic reg_write;
    logic reg_addr;
    logic [15:0] reg_wdata;
    logic [15:0] reg_rdata;
    logic [`RASTER_ADDR_W-1:0] addr_out;
    logic [23:0] color_out;
    logic [31:0] depth_out;
    logic output_valid;
    logic stall_out;
    logic done_out;

    // scoreboard counts
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    int done_count = 0;
    int seed = 90;
    logic [31:0] rnd;
    logic stall_random = 1'b0;
    // current triangle with whole-pixel vertices, shared fraction, flat z and color
    int tv [6];
    logic [15:0] frac;
    logic [31:0] zv;
    logic [23:0] col_v;
    // pixels seen at the outputs and the model's list
    logic [`RASTER_ADDR_W-1:0] got_addr [$];
    logic [23:0] got_color [$];
    logic [31:0] got_depth [$];
    logic [`RASTER_ADDR_W-1:0] exp_addr [$];

    raster_top u_raster_top (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // downstream back-pressure flips a coin when enabled
    initial begin
        stall_in = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            rnd = $random(seed);
            stall_in = stall_random && rnd[0];
        end
    end

    // a pixel leaves on an edge with valid high and no stall
    always @(posedge clock) begin
        if (output_valid && !stall_in) begin
            got_addr.push_back(addr_out);
            got_color.push_back(color_out);
            got_depth.push_back(depth_out);
        end
        if (done_out) begin
            done_count++;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("ERR @%0t: %s", $time, msg);
            errors++;
        end
    endtask

    // cross product of edge a->b with a->p is positive inside a ccw triangle
    function automatic int edge_val(input int ax, ay, bx, by, px, py);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    // covered pixels of tv in row-major order as frame-buffer byte addresses
    task automatic build_expected(input bit both, input int pitch_v,
                                  input logic [`RASTER_ADDR_W-1:0] base);
        int x;
        int y;
        int e1;
        int e2;
        int e3;
        exp_addr.delete();
        // window larger than any test box keeps the row-major order
        for (y = 0; y < 40; y++) begin
            for (x = 0; x < 40; x++) begin
                e1 = edge_val(tv[0], tv[1], tv[2], tv[3], x, y);
                e2 = edge_val(tv[2], tv[3], tv[4], tv[5], x, y);
                e3 = edge_val(tv[4], tv[5], tv[0], tv[1], x, y);
                if ((e1 >= 0 && e2 >= 0 && e3 >= 0)
                        || (both && e1 <= 0 && e2 <= 0 && e3 <= 0)) begin
                    exp_addr.push_back(base
                        + `RASTER_ADDR_W'((y * pitch_v + x) << `RASTER_PIXEL_SHIFT));
                end
            end
        end
    endtask

    // put tv on the pins and raise valid just after an edge
    task automatic load_tri(input logic [`RASTER_ADDR_W-1:0] base, input logic done);
        x1 = {tv[0][15:0], frac};
        y1 = {tv[1][15:0], frac};
        x2 = {tv[2][15:0], frac};
        y2 = {tv[3][15:0], frac};
        x3 = {tv[4][15:0], frac};
        y3 = {tv[5][15:0], frac};
        z1 = zv;
        z2 = zv;
        z3 = zv;
        color1 = col_v;
        addr_in = base;
        done_in = done;
        in_data_valid = 1'b1;
    endtask

    // wait for a free slot and hold valid over the accept edge
    task automatic offer_tri(input logic [`RASTER_ADDR_W-1:0] base, input logic done);
        @(posedge clock);
        #1;
        while (stall_out) begin
            @(posedge clock);
            #1;
        end
        load_tri(base, done);
        @(posedge clock);
        #1;
        in_data_valid = 1'b0;
    endtask

    // stall_out low again means the walk and its last pixel are done
    task automatic wait_idle();
        @(posedge clock);
        #1;
        while (stall_out) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic write_reg(input logic addr, input logic [15:0] data);
        @(posedge clock);
        #1;
        reg_write = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        @(posedge clock);
        #1;
        reg_write = 1'b0;
    endtask

    // pixels from index first on against the model list
    task automatic compare_pixels(input int first);
        int n;
        int i;
        int diff;
        n = got_addr.size() - first;
        check(n == exp_addr.size(),
              $sformatf("got %0d pixels, expected %0d", n, exp_addr.size()));
        for (i = 0; i < n && i < exp_addr.size(); i++) begin
            check(got_addr[first + i] == exp_addr[i],
                  $sformatf("pixel %0d addr %h, expected %h", i, got_addr[first + i],
                            exp_addr[i]));
            check(got_color[first + i] == col_v,
                  $sformatf("pixel %0d color %h, expected %h", i, got_color[first + i], col_v));
            // flat z leaves only truncation in the three products
            diff = $signed(got_depth[first + i] - zv);
            check(diff >= -3 && diff <= 3,
                  $sformatf("pixel %0d depth %h, expected %h", i, got_depth[first + i], zv));
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    `include "raster_tests.svh"

    initial begin
        reset = 1'b0;
        {x1, y1, z1, x2, y2, z2, x3, y3, z3} = '0;
        color1 = '0;
        addr_in = '0;
        in_data_valid = 1'b0;
        done_in = 1'b0;
        reg_write = 1'b0;
        reg_addr = 1'b0;
        reg_wdata = '0;
        frac = '0;
        zv = 32'h0005_8000;
        col_v = 24'h3a7f12;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b1;
        test_coverage();
        test_addressing();
        test_backpressure();
        test_winding();
        test_depth();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
+incdir+verif
src/raster_pkg.sv
src/tri_if.sv
src/raster_regs.sv
src/tri_setup.sv
src/pixel_walker.sv
src/raster_top.sv
verif/raster_props.sv
verif/raster_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the rasterizer testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

# testbench delays need timing support, bound properties need assertions on
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f build.f --top-module raster_tb -Mdir obj_dir

# the log is the only verdict, so an early stop still counts as failure
./obj_dir/Vraster_tb 2>&1 | tee sim.log

if grep -qxF '** PASS **' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
